/* hw/dbg_bus_pkg.sv */
`default_nettype none

// Bus widths seen on the circuit under debug.
package dbg_bus_pkg;

	// Memory write ports a and b.
	localparam int MEM_ADDR_BITS = 32;
	localparam int MEM_DATA_BITS = 64; // Also the width of a stored compare value.

	// The program counter is split into a module number and a state number.
	localparam int PC_MODULE_BITS = 16;
	localparam int PC_STATE_BITS = 16;

	// Halt events are counted modulo 256.
	localparam int HALT_COUNT_BITS = 8;

endpackage

`default_nettype wire

/* hw/trigger_cfg_pkg.sv */
`default_nettype none

// Breakpoint condition settings.
package trigger_cfg_pkg;

	localparam int NUM_CONDITIONS = 4;
	localparam int COND_INDEX_BITS = $clog2(NUM_CONDITIONS); // 2 for four conditions.

	// Relation between the written value and the stored value.
	// All comparisons except ALWAYS and NEVER are unsigned.
	typedef enum logic [2:0] {
		COND_ALWAYS = 3'd0,
		COND_EQ     = 3'd1,
		COND_NE     = 3'd2,
		COND_GE     = 3'd3,
		COND_GT     = 3'd4,
		COND_LE     = 3'd5,
		COND_LT     = 3'd6,
		COND_NEVER  = 3'd7  // Reserved code, never true.
	} cond_op_t;

endpackage

`default_nettype wire

/* hw/trigger_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_config_regs
	import dbg_bus_pkg::*, trigger_cfg_pkg::*;
(
	input  wire logic                       clk,
	input  wire logic                       reset,

	input  wire logic                       config_activate,
	input  wire logic                       config_deactivate,
	input  wire logic [PC_MODULE_BITS-1:0]  config_module,
	input  wire logic [PC_STATE_BITS-1:0]   config_state,

	input  wire logic                       config_cond_en,
	input  wire logic [COND_INDEX_BITS-1:0] config_cond_index,
	input  wire logic [MEM_ADDR_BITS-1:0]   config_cond_addr,
	input  wire logic [MEM_DATA_BITS-1:0]   config_cond_val,
	input  wire cond_op_t                   config_cond_opcode,

	input  wire logic                       config_and_en,
	input  wire logic                       config_and_mode,

	output logic                            armed,
	output logic [PC_MODULE_BITS-1:0]       armed_module,
	output logic [PC_STATE_BITS-1:0]        armed_state,
	output logic                            and_mode,
	output logic [MEM_ADDR_BITS-1:0]        cond_addr [NUM_CONDITIONS],
	output logic [MEM_DATA_BITS-1:0]        cond_val [NUM_CONDITIONS],
	output cond_op_t                        cond_opcode [NUM_CONDITIONS],
	output logic                            cond_clear
);

	// Activate wins over every other strobe sampled in the same cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
		end else if (config_activate) begin
			armed <= 1'b1;
		end else if (config_deactivate) begin
			armed <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (config_activate) begin
			armed_module <= config_module;
			armed_state <= config_state;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			and_mode <= 1'b0; // OR after reset.
		end else if (config_and_en && !config_activate) begin
			and_mode <= config_and_mode;
		end
	end

	// Opcodes fall back to ALWAYS on activate, so a fresh breakpoint starts unconditioned.
	always_ff @(posedge clk) begin
		if (reset || config_activate) begin
			for (int i = 0; i < NUM_CONDITIONS; i++) begin
				cond_opcode[i] <= COND_ALWAYS;
			end
		end else if (config_cond_en) begin
			for (int i = 0; i < NUM_CONDITIONS; i++) begin
				if (config_cond_index == COND_INDEX_BITS'(i))
					cond_opcode[i] <= config_cond_opcode;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (config_cond_en && !config_activate) begin
			for (int i = 0; i < NUM_CONDITIONS; i++) begin
				if (config_cond_index == COND_INDEX_BITS'(i)) begin
					cond_addr[i] <= config_cond_addr;
					cond_val[i] <= config_cond_val;
				end
			end
		end
	end

	// The watchers see the clear one edge after activate.
	always_ff @(posedge clk) begin
		if (reset)
			cond_clear <= 1'b0;
		else
			cond_clear <= config_activate;
	end

endmodule

`default_nettype wire

/* hw/value_compare.sv */
`timescale 1ns/1ps
`default_nettype none

module value_compare
	import dbg_bus_pkg::*, trigger_cfg_pkg::*;
(
	input  wire logic [MEM_DATA_BITS-1:0] write_data,
	input  wire logic [MEM_DATA_BITS-1:0] stored_data,
	input  wire cond_op_t                 opcode,
	output logic                          holds
);

	// The written value is the left operand of every relation.
	always_comb begin
		case (opcode)
			COND_ALWAYS: holds = 1'b1;
			COND_EQ:     holds = (write_data == stored_data);
			COND_NE:     holds = (write_data != stored_data);
			COND_GE:     holds = (write_data >= stored_data);
			COND_GT:     holds = (write_data > stored_data);
			COND_LE:     holds = (write_data <= stored_data);
			COND_LT:     holds = (write_data < stored_data);
			default:     holds = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/condition_watch.sv */
`timescale 1ns/1ps
`default_nettype none

module condition_watch
	import dbg_bus_pkg::*, trigger_cfg_pkg::*;
(
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     cond_clear,

	input  wire logic [MEM_ADDR_BITS-1:0] watch_addr,
	input  wire logic [MEM_DATA_BITS-1:0] watch_val,
	input  wire cond_op_t                 opcode,

	input  wire logic                     wr_en_a,
	input  wire logic [MEM_ADDR_BITS-1:0] addr_a,
	input  wire logic [MEM_DATA_BITS-1:0] writedata_a,

	input  wire logic                     wr_en_b,
	input  wire logic [MEM_ADDR_BITS-1:0] addr_b,
	input  wire logic [MEM_DATA_BITS-1:0] writedata_b,

	output logic                          satisfied
);

	logic hit_a;
	logic hit_b;
	logic holds_a;
	logic holds_b;

	assign hit_a = wr_en_a && (addr_a == watch_addr);
	assign hit_b = wr_en_b && (addr_b == watch_addr);

	value_compare cmp_a (
		.write_data  (writedata_a),
		.stored_data (watch_val),
		.opcode      (opcode),
		.holds       (holds_a)
	);

	value_compare cmp_b (
		.write_data  (writedata_b),
		.stored_data (watch_val),
		.opcode      (opcode),
		.holds       (holds_b)
	);

	// The flag only moves on a write to the watched address.
	// With both ports writing there, port a is the one that counts.
	always_ff @(posedge clk) begin
		if (reset || cond_clear) begin
			satisfied <= 1'b1;
		end else if (hit_a) begin
			satisfied <= holds_a;
		end else if (hit_b) begin
			satisfied <= holds_b;
		end
	end

endmodule

`default_nettype wire

/* hw/breakpoint_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module breakpoint_eval
	import dbg_bus_pkg::*, trigger_cfg_pkg::*;
(
	input  wire logic                      clk,
	input  wire logic                      reset,

	input  wire logic                      armed,
	input  wire logic [PC_MODULE_BITS-1:0] armed_module,
	input  wire logic [PC_STATE_BITS-1:0]  armed_state,
	input  wire logic                      and_mode,
	input  wire logic [NUM_CONDITIONS-1:0] satisfied,

	input  wire logic [PC_MODULE_BITS-1:0] pc_module,
	input  wire logic [PC_STATE_BITS-1:0]  pc_state,
	input  wire logic                      resume,

	output logic                           breakpoint_hit,
	output logic                           halted,
	output logic [HALT_COUNT_BITS-1:0]     halt_count
);

	logic pc_match;
	logic conds_met;
	logic halt_event;

	assign pc_match = (pc_module == armed_module) && (pc_state == armed_state);

	// AND needs every flag, OR needs any one.
	assign conds_met = and_mode ? (&satisfied) : (|satisfied);

	assign breakpoint_hit = armed && pc_match && conds_met;

	// Only a hit that finds the circuit running counts, and resume masks it.
	assign halt_event = breakpoint_hit && !halted && !resume;

	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
		end else if (resume) begin
			halted <= 1'b0;
		end else if (halt_event) begin
			halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			halt_count <= '0;
		else if (halt_event)
			halt_count <= halt_count + 1'b1; // Wraps at the top.
	end

endmodule

`default_nettype wire

/* hw/breakpoint_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

module breakpoint_trigger
	import dbg_bus_pkg::*, trigger_cfg_pkg::*;
(
	input  wire logic                       clk,
	input  wire logic                       reset,

	input  wire logic                       config_activate,
	input  wire logic                       config_deactivate,
	input  wire logic [PC_MODULE_BITS-1:0]  config_module,
	input  wire logic [PC_STATE_BITS-1:0]   config_state,
	input  wire logic                       config_cond_en,
	input  wire logic [COND_INDEX_BITS-1:0] config_cond_index,
	input  wire logic [MEM_ADDR_BITS-1:0]   config_cond_addr,
	input  wire logic [MEM_DATA_BITS-1:0]   config_cond_val,
	input  wire cond_op_t                   config_cond_opcode,
	input  wire logic                       config_and_en,
	input  wire logic                       config_and_mode,
	input  wire logic                       resume,

	input  wire logic [PC_MODULE_BITS-1:0]  pc_module,
	input  wire logic [PC_STATE_BITS-1:0]   pc_state,

	input  wire logic                       wr_en_a,
	input  wire logic [MEM_ADDR_BITS-1:0]   addr_a,
	input  wire logic [MEM_DATA_BITS-1:0]   writedata_a,
	input  wire logic                       wr_en_b,
	input  wire logic [MEM_ADDR_BITS-1:0]   addr_b,
	input  wire logic [MEM_DATA_BITS-1:0]   writedata_b,

	output logic                            breakpoint_hit,
	output logic                            halted,
	output logic [HALT_COUNT_BITS-1:0]      halt_count
);

	logic                      armed;
	logic [PC_MODULE_BITS-1:0] armed_module;
	logic [PC_STATE_BITS-1:0]  armed_state;
	logic                      and_mode;
	logic [MEM_ADDR_BITS-1:0]  cond_addr [NUM_CONDITIONS];
	logic [MEM_DATA_BITS-1:0]  cond_val [NUM_CONDITIONS];
	cond_op_t                  cond_opcode [NUM_CONDITIONS];
	logic                      cond_clear;
	logic [NUM_CONDITIONS-1:0] satisfied;

	trigger_config_regs regs (
		.clk                (clk),
		.reset              (reset),
		.config_activate    (config_activate),
		.config_deactivate  (config_deactivate),
		.config_module      (config_module),
		.config_state       (config_state),
		.config_cond_en     (config_cond_en),
		.config_cond_index  (config_cond_index),
		.config_cond_addr   (config_cond_addr),
		.config_cond_val    (config_cond_val),
		.config_cond_opcode (config_cond_opcode),
		.config_and_en      (config_and_en),
		.config_and_mode    (config_and_mode),
		.armed              (armed),
		.armed_module       (armed_module),
		.armed_state        (armed_state),
		.and_mode           (and_mode),
		.cond_addr          (cond_addr),
		.cond_val           (cond_val),
		.cond_opcode        (cond_opcode),
		.cond_clear         (cond_clear)
	);

	// One watcher per condition, all on the same two write ports.
	for (genvar i = 0; i < NUM_CONDITIONS; i++) begin : g_cond
		condition_watch watch (
			.clk         (clk),
			.reset       (reset),
			.cond_clear  (cond_clear),
			.watch_addr  (cond_addr[i]),
			.watch_val   (cond_val[i]),
			.opcode      (cond_opcode[i]),
			.wr_en_a     (wr_en_a),
			.addr_a      (addr_a),
			.writedata_a (writedata_a),
			.wr_en_b     (wr_en_b),
			.addr_b      (addr_b),
			.writedata_b (writedata_b),
			.satisfied   (satisfied[i])
		);
	end

	breakpoint_eval eval (
		.clk            (clk),
		.reset          (reset),
		.armed          (armed),
		.armed_module   (armed_module),
		.armed_state    (armed_state),
		.and_mode       (and_mode),
		.satisfied      (satisfied),
		.pc_module      (pc_module),
		.pc_state       (pc_state),
		.resume         (resume),
		.breakpoint_hit (breakpoint_hit),
		.halted         (halted),
		.halt_count     (halt_count)
	);

endmodule

`default_nettype wire

/* test/breakpoint_trigger_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module breakpoint_trigger_asserts
	import dbg_bus_pkg::*;
(
	input wire logic                       clk,
	input wire logic                       reset,
	input wire logic                       resume,
	input wire logic                       armed,
	input wire logic                       breakpoint_hit,
	input wire logic                       halted,
	input wire logic [HALT_COUNT_BITS-1:0] halt_count
);

	// Only resume releases a halt.
	halt_holds: assert property (@(posedge clk) disable iff (reset)
		(!halted && $past(halted)) |-> $past(resume) || $past(reset))
		else $error("halted fell without resume");

	no_hit_disarmed: assert property (@(posedge clk) disable iff (reset)
		!armed |-> !breakpoint_hit)
		else $error("breakpoint_hit while disarmed");

	count_on_halt: assert property (@(posedge clk) disable iff (reset)
		(halt_count != $past(halt_count)) |->
			$past(breakpoint_hit && !halted && !resume))
		else $error("halt_count moved without a halt event");

endmodule

bind breakpoint_trigger breakpoint_trigger_asserts chk (
	.clk            (clk),
	.reset          (reset),
	.resume         (resume),
	.armed          (armed),
	.breakpoint_hit (breakpoint_hit),
	.halted         (halted),
	.halt_count     (halt_count)
);

`default_nettype wire

/* test/breakpoint_trigger_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module breakpoint_trigger_tb
	import dbg_bus_pkg::*, trigger_cfg_pkg::*;
();

	logic                       clk = 1'b0;
	logic                       reset;
	logic                       config_activate;
	logic                       config_deactivate;
	logic [PC_MODULE_BITS-1:0]  config_module;
	logic [PC_STATE_BITS-1:0]   config_state;
	logic                       config_cond_en;
	logic [COND_INDEX_BITS-1:0] config_cond_index;
	logic [MEM_ADDR_BITS-1:0]   config_cond_addr;
	logic [MEM_DATA_BITS-1:0]   config_cond_val;
	cond_op_t                   config_cond_opcode;
	logic                       config_and_en;
	logic                       config_and_mode;
	logic                       resume;
	logic [PC_MODULE_BITS-1:0]  pc_module;
	logic [PC_STATE_BITS-1:0]   pc_state;
	logic                       wr_en_a;
	logic [MEM_ADDR_BITS-1:0]   addr_a;
	logic [MEM_DATA_BITS-1:0]   writedata_a;
	logic                       wr_en_b;
	logic [MEM_ADDR_BITS-1:0]   addr_b;
	logic [MEM_DATA_BITS-1:0]   writedata_b;
	logic                       breakpoint_hit;
	logic                       halted;
	logic [HALT_COUNT_BITS-1:0] halt_count;

	// Reference model state, updated on the same edges as the DUT.
	logic                       m_armed;
	logic [PC_MODULE_BITS-1:0]  m_module;
	logic [PC_STATE_BITS-1:0]   m_state;
	logic                       m_and;
	logic [MEM_ADDR_BITS-1:0]   m_addr [NUM_CONDITIONS];
	logic [MEM_DATA_BITS-1:0]   m_val [NUM_CONDITIONS];
	logic [2:0]                 m_op [NUM_CONDITIONS];
	logic                       m_clear;
	logic [NUM_CONDITIONS-1:0]  m_sat;
	logic                       m_halted;
	logic [HALT_COUNT_BITS-1:0] m_count;

	int seed = 4;
	int cur_test = 0;
	int test_errors = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int watchdog_cycles = 0;

	breakpoint_trigger uut (.*);

	always #5 clk = ~clk;

	// Relation table: written value on the left, stored value on the right.
	function automatic logic rel_holds(input logic [2:0] op, input logic [63:0] w,
			input logic [63:0] s);
		case (op)
			3'd0: return 1'b1;
			3'd1: return w == s;
			3'd2: return w != s;
			3'd3: return w >= s;
			3'd4: return w > s;
			3'd5: return w <= s;
			3'd6: return w < s;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic model_hit();
		logic conds;
		conds = m_and ? (&m_sat) : (|m_sat);
		return m_armed && pc_module == m_module && pc_state == m_state && conds;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			m_armed <= 1'b0;
			m_and <= 1'b0;
			m_clear <= 1'b0;
			m_sat <= '1;
			m_halted <= 1'b0;
			m_count <= '0;
			for (int i = 0; i < NUM_CONDITIONS; i++)
				m_op[i] <= 3'd0;
		end else begin
			if (config_activate) begin
				m_armed <= 1'b1;
				m_module <= config_module;
				m_state <= config_state;
			end else if (config_deactivate) begin
				m_armed <= 1'b0;
			end
			if (config_and_en && !config_activate)
				m_and <= config_and_mode;
			m_clear <= config_activate;
			for (int i = 0; i < NUM_CONDITIONS; i++) begin
				if (config_activate) begin
					m_op[i] <= 3'd0;
				end else if (config_cond_en && config_cond_index == i) begin
					m_op[i] <= config_cond_opcode;
					m_addr[i] <= config_cond_addr;
					m_val[i] <= config_cond_val;
				end
				if (m_clear)
					m_sat[i] <= 1'b1;
				else if (wr_en_a && addr_a == m_addr[i])
					m_sat[i] <= rel_holds(m_op[i], writedata_a, m_val[i]);
				else if (wr_en_b && addr_b == m_addr[i])
					m_sat[i] <= rel_holds(m_op[i], writedata_b, m_val[i]);
			end
			if (resume) begin
				m_halted <= 1'b0;
			end else if (model_hit() && !m_halted) begin
				m_halted <= 1'b1;
				m_count <= m_count + 8'd1;
			end
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("[FAIL] test %0d %s: got %h, expected %h", cur_test, name, got, expected);
			test_errors++;
			errors++;
		end
	endtask

	task automatic finish_test();
		if (cur_test != 0) begin
			if (test_errors == 0) begin
				$display("Test %0d finished: passed", cur_test);
				tests_passed++;
			end else begin
				$display("Test %0d finished: failed with %0d mismatches", cur_test, test_errors);
				tests_failed++;
			end
		end
		test_errors = 0;
	endtask

	task automatic clear_strobes();
		config_activate = 1'b0;
		config_deactivate = 1'b0;
		config_cond_en = 1'b0;
		config_and_en = 1'b0;
		resume = 1'b0;
		wr_en_a = 1'b0;
		wr_en_b = 1'b0;
	endtask

	task automatic drive_cond(input logic [63:0] index, input logic [63:0] addr,
			input logic [63:0] val, input logic [63:0] op);
		config_cond_en = 1'b1;
		config_cond_index = index[COND_INDEX_BITS-1:0];
		config_cond_addr = addr[MEM_ADDR_BITS-1:0];
		config_cond_val = val;
		config_cond_opcode = cond_op_t'(op[2:0]);
	endtask

	// Writes values below, equal to and above 0x50 into condition 0 and checks each hit.
	task automatic sweep_opcode(input logic [63:0] op, input logic [63:0] exp_below,
			input logic [63:0] exp_equal, input logic [63:0] exp_above);
		logic [63:0] probe [3];
		logic [63:0] expected [3];
		probe = '{64'h4f, 64'h50, 64'h51};
		expected = '{exp_below, exp_equal, exp_above};
		drive_cond(0, 64'h100, 64'h50, op);
		for (int k = 0; k < 3; k++) begin
			@(negedge clk);
			clear_strobes();
			wr_en_a = 1'b1;
			addr_a = 32'h100;
			writedata_a = probe[k];
			@(negedge clk);
			clear_strobes();
			#1;
			check_value("model breakpoint_hit", 64'(model_hit()), expected[k]);
			check_value("breakpoint_hit", 64'(breakpoint_hit), expected[k]);
		end
	endtask

	task automatic random_traffic(input int cycles);
		repeat (cycles) begin
			wr_en_a = 1'($random(seed));
			addr_a = 32'hf000_0000 | (32'($random(seed)) & 32'h0fff_ffff);
			writedata_a = {32'($random(seed)), 32'($random(seed))};
			wr_en_b = 1'($random(seed));
			addr_b = 32'hf000_0000 | (32'($random(seed)) & 32'h0fff_ffff);
			writedata_b = {32'($random(seed)), 32'($random(seed))};
			@(negedge clk);
		end
	endtask

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired before the test data was finished");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int fd;
		int lines;
		int tnum;
		string line;
		string kind;
		logic [63:0] f0;
		logic [63:0] f1;
		logic [63:0] f2;
		logic [63:0] f3;
		reset = 1'b1;
		clear_strobes();
		config_module = '0;
		config_state = '0;
		config_cond_index = '0;
		config_cond_addr = '0;
		config_cond_val = '0;
		config_cond_opcode = COND_ALWAYS;
		config_and_mode = 1'b0;
		pc_module = '0;
		pc_state = '0;
		addr_a = '0;
		writedata_a = '0;
		addr_b = '0;
		writedata_b = '0;
		lines = 0;
		fd = $fopen("test/breakpoint_trigger_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			$display("Some tests failed");
			$finish;
		end else begin
			while ($fgets(line, fd) != 0)
				lines++;
			$fclose(fd);
			watchdog_cycles = lines * 20 + 16;
			repeat (16) @(posedge clk);
			@(negedge clk);
			reset = 1'b0;
			fd = $fopen("test/breakpoint_trigger_tests.txt", "r");
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				f0 = '0;
				f1 = '0;
				f2 = '0;
				f3 = '0;
				void'($sscanf(line, "%d %s %h %h %h %h", tnum, kind, f0, f1, f2, f3));
				if (tnum != cur_test) begin
					finish_test();
					cur_test = tnum;
				end
				@(negedge clk);
				clear_strobes();
				case (kind)
					"config": begin
						config_activate = f0[0];
						config_deactivate = !f0[0];
						config_module = f1[PC_MODULE_BITS-1:0];
						config_state = f2[PC_STATE_BITS-1:0];
					end
					"cond": drive_cond(f0, f1, f2, f3);
					"andmode": begin
						config_and_en = 1'b1;
						config_and_mode = f0[0];
					end
					"write": begin
						wr_en_a = f0[0];
						wr_en_b = f0[1];
						addr_a = f1[MEM_ADDR_BITS-1:0];
						addr_b = f1[MEM_ADDR_BITS-1:0];
						writedata_a = f2;
						writedata_b = f3;
					end
					"pc": begin
						pc_module = f0[PC_MODULE_BITS-1:0];
						pc_state = f1[PC_STATE_BITS-1:0];
					end
					"resume": begin
						// Resume stays up a second cycle, where it meets any hit with halted low.
						resume = 1'b1;
						@(negedge clk);
					end
					"sweep": sweep_opcode(f0, f1, f2, f3);
					"filler": random_traffic(int'(f0));
					"check": begin
						#1;
						check_value("model breakpoint_hit", 64'(model_hit()), f0);
						check_value("model halted", 64'(m_halted), f1);
						check_value("model halt_count", 64'(m_count), f2);
						check_value("breakpoint_hit", 64'(breakpoint_hit), f0);
						check_value("halted", 64'(halted), f1);
						check_value("halt_count", 64'(halt_count), f2);
					end
					default: begin
						$display("Test %0d has an unknown operation %s", cur_test, kind);
						test_errors++;
						errors++;
					end
				endcase
			end
			$fclose(fd);
			finish_test();
			$display("%0d tests passed, %0d tests failed, %0d mismatches",
				tests_passed, tests_failed, errors);
			if (errors == 0 && tests_failed == 0)
				$display("All tests passed");
			else
				$display("Some tests failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* test/breakpoint_trigger_tests.txt */
# test kind fields (hex): config act mod state | cond idx addr val op | andmode m
# write mask(1=a,2=b) addr data_a data_b | pc mod state | sweep op below equal above | check hit halted count
1 cond 1 104 10 0
1 cond 2 108 10 0
1 cond 3 10c 10 0
1 andmode 1
1 config 1 1 2
1 pc 1 2
1 check 1 1 1
1 sweep 0 1 1 1
1 sweep 1 0 1 0
1 sweep 2 1 0 1
1 sweep 3 0 1 1
1 sweep 4 0 0 1
1 sweep 5 1 1 0
1 sweep 6 1 0 0
1 sweep 7 0 0 0
1 check 0 1 1
2 andmode 0
2 check 1 1 1
2 cond 1 104 10 1
2 cond 2 108 10 1
2 cond 3 10c 10 1
2 write 1 104 11 0
2 write 1 108 11 0
2 write 1 10c 11 0
2 check 0 1 1
2 filler 8
2 check 0 1 1
2 write 1 108 10 0
2 check 1 1 1
2 andmode 1
2 check 0 1 1
2 cond 0 100 50 1
2 write 1 100 50 0
2 write 1 104 10 0
2 write 1 10c 10 0
2 check 1 1 1
3 write 3 104 11 10
3 check 0 1 1
3 write 3 104 10 11
3 check 1 1 1
3 write 2 104 0 11
3 check 0 1 1
3 write 1 104 10 0
3 check 1 1 1
4 pc 1 3
4 check 0 1 1
4 pc 2 2
4 check 0 1 1
4 pc 1 2
4 check 1 1 1
4 config 0 0 0
4 check 0 1 1
4 write 1 100 0 0
4 config 1 1 2
4 check 0 1 1
4 check 1 1 1
5 resume
5 check 1 0 1
5 check 1 1 2
5 check 1 1 2
5 pc 0 0
5 resume
5 check 0 0 2
5 pc 1 2
5 check 1 1 3

/* breakpoint_trigger.f */
hw/dbg_bus_pkg.sv
hw/trigger_cfg_pkg.sv
hw/trigger_config_regs.sv
hw/value_compare.sv
hw/condition_watch.sv
hw/breakpoint_eval.sv
hw/breakpoint_trigger.sv
test/breakpoint_trigger_asserts.sv
test/breakpoint_trigger_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the breakpoint trigger testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f breakpoint_trigger.f \
	--top-module breakpoint_trigger_tb \
	--Mdir obj_dir -o breakpoint_trigger_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/breakpoint_trigger_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi

exit 0
